// ==== design/alu_unit.sv ====
`timescale 1ns/100ps

module alu_unit import core_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     issue_valid,
	input  alu_op_t  op,
	input  word_t    a,
	input  word_t    b,
	input  rob_tag_t tag,
	output logic     free,
	output cdb_t     req,
	input  logic     grant
);

	word_t    result;
	logic     hold_valid;
	rob_tag_t hold_tag;
	word_t    hold_value;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			// signed compare
			ALU_SLT: result = word_t'($signed(a) < $signed(b));
			default: result = '0;
		endcase
	end

	// hold register frees as it is granted
	assign free = !hold_valid || grant;
	assign req  = '{valid: hold_valid, tag: hold_tag, value: hold_value};

	always_ff @(posedge clock) begin
		if (reset) begin
			hold_valid <= 1'b0;
		end else if (issue_valid) begin
			hold_valid <= 1'b1;
		end else if (grant) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (issue_valid) begin
			hold_tag   <= tag;
			hold_value <= result;
		end
	end

endmodule

// ==== design/cdb_arbiter.sv ====
`timescale 1ns/100ps

module cdb_arbiter import core_pkg::*; (
	input  cdb_t alu_req,
	input  cdb_t mul_req,
	output logic alu_grant,
	output logic mul_grant,
	output cdb_t cdb
);

	// multiplier has fixed priority
	assign mul_grant = mul_req.valid;
	assign alu_grant = alu_req.valid && !mul_req.valid;

	// winner drives the bus, idle bus carries valid low
	assign cdb = mul_req.valid ? mul_req : alu_req;

	// one winner per cycle
	always_comb begin
		assert final (!(alu_grant && mul_grant));
	end

endmodule

// ==== design/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath width
`define XLEN 32

// architectural registers, r0 hardwired to zero
`define NUM_REGS 32

// reorder buffer entries, power of two
`define ROB_DEPTH 8

// entries per reservation station
`define RS_DEPTH 4

// shift-add iterations per multiply
`define MUL_STEPS 32

`endif

// ==== design/core_pkg.sv ====
`include "core_defs.svh"

package core_pkg;

	// basic fields
	typedef logic [`XLEN-1:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

	// alu opcodes, match issue_op[2:0]
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5
	} alu_op_t;

	// multiply flavours, match issue_op[0]
	typedef enum logic [0:0] {
		MUL_LO = 1'b0,
		MUL_HU = 1'b1
	} mul_op_t;

	// which station a dispatch goes to
	typedef enum logic {
		UNIT_ALU = 1'b0,
		UNIT_MUL = 1'b1
	} unit_sel_t;

	// source operand, either a value or a pending rob tag
	typedef struct packed {
		logic     ready;
		rob_tag_t tag;
		word_t    value;
	} operand_t;

	// common data bus result
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		word_t    value;
	} cdb_t;

endpackage

// ==== design/dispatch_if.sv ====
`timescale 1ns/100ps

interface dispatch_if import core_pkg::*; ();

	// one renamed instruction per cycle
	logic      valid;
	unit_sel_t sel;
	rob_tag_t  tag;
	alu_op_t   alu_op;
	mul_op_t   mul_op;
	operand_t  src1;
	operand_t  src2;

	// rename side
	modport source (
		output valid, sel, tag, alu_op, mul_op, src1, src2
	);

	// station side
	modport sink (
		input valid, sel, tag, alu_op, mul_op, src1, src2
	);

endinterface

// ==== design/mul_unit.sv ====
`timescale 1ns/100ps
`include "core_defs.svh"

module mul_unit import core_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     start,
	input  mul_op_t  op,
	input  word_t    a,
	input  word_t    b,
	input  rob_tag_t tag,
	output logic     idle,
	output cdb_t     req,
	input  logic     grant
);

	localparam int CNT_W = $clog2(`MUL_STEPS);

	typedef enum logic [1:0] {
		MUL_IDLE,
		MUL_RUN,
		MUL_DONE
	} mul_state_t;

	mul_state_t         state_q;
	logic [CNT_W-1:0]   step_q;
	logic [2*`XLEN-1:0] mcand_q;
	logic [2*`XLEN-1:0] acc_q;
	word_t              mplier_q;
	mul_op_t            op_q;
	rob_tag_t           tag_q;

	assign idle = state_q == MUL_IDLE;
	assign req  = '{valid: state_q == MUL_DONE, tag: tag_q,
		value: op_q == MUL_HU ? acc_q[2*`XLEN-1:`XLEN] : acc_q[`XLEN-1:0]};

	//////////////////////////////////////////////////
	// sequencer

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= MUL_IDLE;
			step_q  <= '0;
		end else begin
			case (state_q)
				MUL_IDLE: if (start) begin
					state_q <= MUL_RUN;
					step_q  <= '0;
				end
				MUL_RUN: begin
					step_q <= step_q + 1'b1;
					if (step_q == CNT_W'(`MUL_STEPS - 1)) begin
						state_q <= MUL_DONE;
					end
				end
				// wait for the bus
				MUL_DONE: if (grant) begin
					state_q <= MUL_IDLE;
				end
				default: state_q <= MUL_IDLE;
			endcase
		end
	end

	// unsigned shift-add, one multiplier bit per step
	always_ff @(posedge clock) begin
		if (start) begin
			mcand_q  <= {{`XLEN{1'b0}}, a};
			mplier_q <= b;
			acc_q    <= '0;
			op_q     <= op;
			tag_q    <= tag;
		end else if (state_q == MUL_RUN) begin
			if (mplier_q[0]) begin
				acc_q <= acc_q + mcand_q;
			end
			mcand_q  <= mcand_q << 1;
			mplier_q <= mplier_q >> 1;
		end
	end

	// station must hold multiplies while busy
	assert property (@(posedge clock) disable iff (reset) start |-> state_q == MUL_IDLE);

endmodule

// ==== design/ooo_core.sv ====
`timescale 1ns/100ps

module ooo_core import core_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       issue_valid,
	output logic       issue_ready,
	input  logic [3:0] issue_op,
	input  reg_idx_t   issue_rd,
	input  reg_idx_t   issue_rs1,
	input  reg_idx_t   issue_rs2,
	input  logic       issue_use_imm,
	input  word_t      issue_imm,
	output logic       commit_valid,
	output reg_idx_t   commit_rd,
	output word_t      commit_data
);

	// rob side
	logic     rob_full;
	logic     rob_alloc;
	rob_tag_t rob_alloc_tag;
	rob_tag_t rob_read_tag1;
	rob_tag_t rob_read_tag2;
	operand_t rob_read1;
	operand_t rob_read2;
	rob_tag_t commit_tag;

	// stations to units
	logic     alu_rs_full;
	logic     alu_issue;
	alu_op_t  alu_op;
	word_t    alu_a;
	word_t    alu_b;
	rob_tag_t alu_tag;
	logic     mul_rs_full;
	logic     mul_issue;
	mul_op_t  mul_op;
	word_t    mul_a;
	word_t    mul_b;
	rob_tag_t mul_tag;

	// execute and bus
	logic alu_free;
	logic mul_idle;
	cdb_t alu_req;
	cdb_t mul_req;
	logic alu_grant;
	logic mul_grant;
	cdb_t cdb;

	dispatch_if dsp ();

	//////////////////////////////////////////////////
	// rename and rob

	rename_stage rename (
		.clock         (clock),
		.reset         (reset),
		.issue_valid   (issue_valid),
		.issue_ready   (issue_ready),
		.issue_op      (issue_op),
		.issue_rd      (issue_rd),
		.issue_rs1     (issue_rs1),
		.issue_rs2     (issue_rs2),
		.issue_use_imm (issue_use_imm),
		.issue_imm     (issue_imm),
		.rob_full      (rob_full),
		.rob_alloc_tag (rob_alloc_tag),
		.rob_alloc     (rob_alloc),
		.rob_read_tag1 (rob_read_tag1),
		.rob_read_tag2 (rob_read_tag2),
		.rob_read1     (rob_read1),
		.rob_read2     (rob_read2),
		.alu_rs_full   (alu_rs_full),
		.mul_rs_full   (mul_rs_full),
		.cdb           (cdb),
		.commit_valid  (commit_valid),
		.commit_tag    (commit_tag),
		.commit_rd     (commit_rd),
		.commit_data   (commit_data),
		.dsp           (dsp.source)
	);

	reorder_buffer rob (
		.clock        (clock),
		.reset        (reset),
		.alloc        (rob_alloc),
		.alloc_rd     (issue_rd),
		.full         (rob_full),
		.alloc_tag    (rob_alloc_tag),
		.read_tag1    (rob_read_tag1),
		.read_tag2    (rob_read_tag2),
		.read1        (rob_read1),
		.read2        (rob_read2),
		.cdb          (cdb),
		.commit_valid (commit_valid),
		.commit_tag   (commit_tag),
		.commit_rd    (commit_rd),
		.commit_data  (commit_data)
	);

	//////////////////////////////////////////////////
	// stations

	reservation_station #(.payload_t(alu_op_t), .unit(UNIT_ALU)) alu_rs (
		.clock         (clock),
		.reset         (reset),
		.dsp           (dsp.sink),
		.cdb           (cdb),
		.unit_free     (alu_free),
		.full          (alu_rs_full),
		.issue_valid   (alu_issue),
		.issue_payload (alu_op),
		.issue_a       (alu_a),
		.issue_b       (alu_b),
		.issue_tag     (alu_tag)
	);

	reservation_station #(.payload_t(mul_op_t), .unit(UNIT_MUL)) mul_rs (
		.clock         (clock),
		.reset         (reset),
		.dsp           (dsp.sink),
		.cdb           (cdb),
		.unit_free     (mul_idle),
		.full          (mul_rs_full),
		.issue_valid   (mul_issue),
		.issue_payload (mul_op),
		.issue_a       (mul_a),
		.issue_b       (mul_b),
		.issue_tag     (mul_tag)
	);

	//////////////////////////////////////////////////
	// execute and common data bus

	alu_unit alu (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (alu_issue),
		.op          (alu_op),
		.a           (alu_a),
		.b           (alu_b),
		.tag         (alu_tag),
		.free        (alu_free),
		.req         (alu_req),
		.grant       (alu_grant)
	);

	mul_unit mul (
		.clock (clock),
		.reset (reset),
		.start (mul_issue),
		.op    (mul_op),
		.a     (mul_a),
		.b     (mul_b),
		.tag   (mul_tag),
		.idle  (mul_idle),
		.req   (mul_req),
		.grant (mul_grant)
	);

	cdb_arbiter arbiter (
		.alu_req   (alu_req),
		.mul_req   (mul_req),
		.alu_grant (alu_grant),
		.mul_grant (mul_grant),
		.cdb       (cdb)
	);

endmodule

// ==== design/rename_stage.sv ====
`timescale 1ns/100ps
`include "core_defs.svh"

module rename_stage import core_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     issue_valid,
	output logic     issue_ready,
	input  logic [3:0] issue_op,
	input  reg_idx_t issue_rd,
	input  reg_idx_t issue_rs1,
	input  reg_idx_t issue_rs2,
	input  logic     issue_use_imm,
	input  word_t    issue_imm,
	input  logic     rob_full,
	input  rob_tag_t rob_alloc_tag,
	output logic     rob_alloc,
	output rob_tag_t rob_read_tag1,
	output rob_tag_t rob_read_tag2,
	input  operand_t rob_read1,
	input  operand_t rob_read2,
	input  logic     alu_rs_full,
	input  logic     mul_rs_full,
	input  cdb_t     cdb,
	input  logic     commit_valid,
	input  rob_tag_t commit_tag,
	input  reg_idx_t commit_rd,
	input  word_t    commit_data,
	dispatch_if.source dsp
);

	// architectural state and map table
	word_t    regs [`NUM_REGS];
	logic     busy [`NUM_REGS];
	rob_tag_t map_tag [`NUM_REGS];

	unit_sel_t unit_sel;
	logic      accept;

	// register file, then rob, then this cycle's bus
	function automatic operand_t read_source(input reg_idx_t rs, input operand_t rob_rd);
		operand_t src;
		src.tag   = map_tag[rs];
		src.ready = 1'b1;
		src.value = regs[rs];
		if (busy[rs]) begin
			if (rob_rd.ready) begin
				src.value = rob_rd.value;
			end else if (cdb.valid && cdb.tag == map_tag[rs]) begin
				src.value = cdb.value;
			end else begin
				src.ready = 1'b0;
				src.value = '0;
			end
		end
		return src;
	endfunction

	//////////////////////////////////////////////////
	// decode and accept

	// bit 3 marks a multiply
	assign unit_sel    = issue_op[3] ? UNIT_MUL : UNIT_ALU;
	assign issue_ready = !rob_full && !(unit_sel == UNIT_MUL ? mul_rs_full : alu_rs_full);
	assign accept      = issue_valid && issue_ready;
	assign rob_alloc   = accept;

	// rob lookups follow the map table
	assign rob_read_tag1 = map_tag[issue_rs1];
	assign rob_read_tag2 = map_tag[issue_rs2];

	assign dsp.valid  = accept;
	assign dsp.sel    = unit_sel;
	assign dsp.tag    = rob_alloc_tag;
	assign dsp.alu_op = alu_op_t'(issue_op[2:0]);
	assign dsp.mul_op = mul_op_t'(issue_op[0]);
	assign dsp.src1   = read_source(issue_rs1, rob_read1);
	// immediate replaces the second source
	assign dsp.src2   = issue_use_imm ? operand_t'{ready: 1'b1, tag: '0, value: issue_imm}
		: read_source(issue_rs2, rob_read2);

	//////////////////////////////////////////////////
	// commit writes and map updates

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i]    <= '0;
				busy[i]    <= 1'b0;
				map_tag[i] <= '0;
			end
		end else begin
			if (commit_valid && commit_rd != '0) begin
				regs[commit_rd] <= commit_data;
				// only the youngest writer frees the register
				if (map_tag[commit_rd] == commit_tag) begin
					busy[commit_rd] <= 1'b0;
				end
			end
			// new dispatch overrides a same-cycle commit clear
			if (accept && issue_rd != '0) begin
				busy[issue_rd]    <= 1'b1;
				map_tag[issue_rd] <= rob_alloc_tag;
			end
		end
	end

endmodule

// ==== design/reorder_buffer.sv ====
`timescale 1ns/100ps
`include "core_defs.svh"

module reorder_buffer import core_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     alloc,
	input  reg_idx_t alloc_rd,
	output logic     full,
	output rob_tag_t alloc_tag,
	input  rob_tag_t read_tag1,
	input  rob_tag_t read_tag2,
	output operand_t read1,
	output operand_t read2,
	input  cdb_t     cdb,
	output logic     commit_valid,
	output rob_tag_t commit_tag,
	output reg_idx_t commit_rd,
	output word_t    commit_data
);

	localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

	// per entry fields
	reg_idx_t rd_q    [`ROB_DEPTH];
	word_t    value_q [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0] ready_q;

	// circular pointers
	rob_tag_t         head_q;
	rob_tag_t         tail_q;
	logic [CNT_W-1:0] count_q;

	assign full      = count_q == CNT_W'(`ROB_DEPTH);
	assign alloc_tag = tail_q;

	// operand reads for rename
	assign read1 = '{ready: ready_q[read_tag1], tag: read_tag1, value: value_q[read_tag1]};
	assign read2 = '{ready: ready_q[read_tag2], tag: read_tag2, value: value_q[read_tag2]};

	// head leaves once its result is in
	// ready bits clear on commit so an empty buffer never commits
	assign commit_valid = ready_q[head_q];
	assign commit_tag   = head_q;
	assign commit_rd    = rd_q[head_q];
	assign commit_data  = value_q[head_q];

	//////////////////////////////////////////////////
	// pointers and ready flags

	always_ff @(posedge clock) begin
		if (reset) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
			ready_q <= '0;
		end else begin
			if (cdb.valid) begin
				ready_q[cdb.tag] <= 1'b1;
			end
			if (commit_valid) begin
				ready_q[head_q] <= 1'b0;
				head_q          <= head_q + 1'b1;
			end
			if (alloc) begin
				ready_q[tail_q] <= 1'b0;
				tail_q          <= tail_q + 1'b1;
			end
			count_q <= count_q + CNT_W'(alloc) - CNT_W'(commit_valid);
		end
	end

	// payload
	always_ff @(posedge clock) begin
		if (alloc) begin
			rd_q[tail_q] <= alloc_rd;
		end
		if (cdb.valid) begin
			value_q[cdb.tag] <= cdb.value;
		end
	end

	// rename must stall when full, and no stale ready bit may commit
	assert property (@(posedge clock) disable iff (reset)
		!(alloc && full) && !(commit_valid && count_q == '0));

endmodule

// ==== design/reservation_station.sv ====
`timescale 1ns/100ps
`include "core_defs.svh"

module reservation_station import core_pkg::*; #(
	parameter type       payload_t = alu_op_t,
	parameter unit_sel_t unit      = UNIT_ALU
) (
	input  logic     clock,
	input  logic     reset,
	dispatch_if.sink dsp,
	input  cdb_t     cdb,
	input  logic     unit_free,
	output logic     full,
	output logic     issue_valid,
	output payload_t issue_payload,
	output word_t    issue_a,
	output word_t    issue_b,
	output rob_tag_t issue_tag
);

	localparam int IDX_W = $clog2(`RS_DEPTH);

	logic [`RS_DEPTH-1:0] valid_q;
	payload_t payload_q [`RS_DEPTH];
	rob_tag_t tag_q     [`RS_DEPTH];
	operand_t src1_q    [`RS_DEPTH];
	operand_t src2_q    [`RS_DEPTH];

	payload_t         new_payload;
	logic             alloc;
	logic             pick_found;
	logic [IDX_W-1:0] free_idx;
	logic [IDX_W-1:0] pick_idx;

	// fill a missing source from the bus
	function automatic operand_t snoop(input operand_t src, input cdb_t bus);
		operand_t res;
		res = src;
		if (!src.ready && bus.valid && bus.tag == src.tag) begin
			res.ready = 1'b1;
			res.value = bus.value;
		end
		return res;
	endfunction

	// opcode field for this unit
	if (unit == UNIT_ALU) begin : g_alu_payload
		assign new_payload = payload_t'(dsp.alu_op);
	end else begin : g_mul_payload
		assign new_payload = payload_t'(dsp.mul_op);
	end

	assign full  = &valid_q;
	assign alloc = dsp.valid && dsp.sel == unit;

	// lowest free slot and lowest ready entry
	always_comb begin
		free_idx   = '0;
		pick_idx   = '0;
		pick_found = 1'b0;
		for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
			if (!valid_q[i]) begin
				free_idx = IDX_W'(i);
			end
			if (valid_q[i] && src1_q[i].ready && src2_q[i].ready) begin
				pick_idx   = IDX_W'(i);
				pick_found = 1'b1;
			end
		end
	end

	assign issue_valid   = pick_found && unit_free;
	assign issue_payload = payload_q[pick_idx];
	assign issue_a       = src1_q[pick_idx].value;
	assign issue_b       = src2_q[pick_idx].value;
	assign issue_tag     = tag_q[pick_idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
		end else begin
			if (issue_valid) begin
				valid_q[pick_idx] <= 1'b0;
			end
			if (alloc) begin
				valid_q[free_idx] <= 1'b1;
			end
		end
	end

	// wakeup, then a new fill overwrites its slot
	always_ff @(posedge clock) begin
		for (int i = 0; i < `RS_DEPTH; i++) begin
			src1_q[i] <= snoop(src1_q[i], cdb);
			src2_q[i] <= snoop(src2_q[i], cdb);
		end
		if (alloc) begin
			payload_q[free_idx] <= new_payload;
			tag_q[free_idx]     <= dsp.tag;
			src1_q[free_idx]    <= dsp.src1;
			src2_q[free_idx]    <= dsp.src2;
		end
	end

	// single issue port
	assert property (@(posedge clock) disable iff (reset)
		$countones($past(valid_q) & ~valid_q) <= 1);

endmodule

// ==== dv/ooo_core_tb.sv ====
`timescale 1ns/100ps

module ooo_core_tb import core_pkg::*; ();

	// instruction counts per test
	localparam int N_RANDOM = 60;
	localparam int N_CHAIN  = 43;
	localparam int N_MUL    = 20;
	localparam int N_FLOOD  = 30;
	localparam int N_ZERO   = 6;
	localparam int NUM_INSTR = N_RANDOM + N_CHAIN + N_MUL + N_FLOOD + N_ZERO;
	localparam int TIMEOUT_CYCLES = 100 + 40 * NUM_INSTR;

	logic       clock;
	logic       reset;
	logic       issue_valid;
	logic       issue_ready;
	logic [3:0] issue_op;
	reg_idx_t   issue_rd;
	reg_idx_t   issue_rs1;
	reg_idx_t   issue_rs2;
	logic       issue_use_imm;
	word_t      issue_imm;
	logic       commit_valid;
	reg_idx_t   commit_rd;
	word_t      commit_data;

	// register model and expected commits
	word_t    model_regs [32];
	reg_idx_t exp_rd_q [$];
	word_t    exp_data_q [$];
	logic     exp_empty;
	reg_idx_t exp_head_rd;
	word_t    exp_head_data;
	logic     accepted_last;
	int       accepted;
	int       committed;
	int       stall_cycles;
	int       cycle_count;
	word_t    op_a;
	word_t    op_b;
	word_t    result;

	tb_clock clk_gen (
		.clock (clock),
		.reset (reset)
	);

	ooo_core UUT (
		.clock         (clock),
		.reset         (reset),
		.issue_valid   (issue_valid),
		.issue_ready   (issue_ready),
		.issue_op      (issue_op),
		.issue_rd      (issue_rd),
		.issue_rs1     (issue_rs1),
		.issue_rs2     (issue_rs2),
		.issue_use_imm (issue_use_imm),
		.issue_imm     (issue_imm),
		.commit_valid  (commit_valid),
		.commit_rd     (commit_rd),
		.commit_data   (commit_data)
	);

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	// wrapped 32-bit results, unsigned 64-bit product
	function automatic word_t expected_result(input logic [3:0] op, input word_t a, input word_t b);
		logic [63:0] prod;
		prod = {32'd0, a} * {32'd0, b};
		case (op)
			4'd0: return a + b;
			4'd1: return a - b;
			4'd2: return a & b;
			4'd3: return a | b;
			4'd4: return a ^ b;
			4'd5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			4'd8: return prod[31:0];
			4'd9: return prod[63:32];
			default: return '0;
		endcase
	endfunction

	////////////////////////////////////////////////////
	// timeout

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			stop_with_failure("timeout: not every instruction committed in time");
		end
	end

	////////////////////////////////////////////////////
	// model and accept tracking

	always @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				model_regs[i] = '0;
			end
			exp_rd_q.delete();
			exp_data_q.delete();
			accepted_last = 1'b0;
		end else begin
			// head leaves on each commit
			if (commit_valid) begin
				if (exp_rd_q.size() > 0) begin
					void'(exp_rd_q.pop_front());
					void'(exp_data_q.pop_front());
				end
				committed++;
			end
			// back-pressure seen while offering an instruction
			if (issue_valid && !issue_ready) begin
				stall_cycles++;
			end
			accepted_last = issue_valid && issue_ready;
			if (accepted_last) begin
				op_a   = model_regs[issue_rs1];
				op_b   = issue_use_imm ? issue_imm : model_regs[issue_rs2];
				result = expected_result(issue_op, op_a, op_b);
				// r0 keeps zero but still commits its value
				if (issue_rd != '0) begin
					model_regs[issue_rd] = result;
				end
				exp_rd_q.push_back(issue_rd);
				exp_data_q.push_back(result);
				accepted++;
			end
		end
		exp_empty = exp_rd_q.size() == 0;
		if (!exp_empty) begin
			exp_head_rd   = exp_rd_q[0];
			exp_head_data = exp_data_q[0];
		end
	end

	////////////////////////////////////////////////////
	// checks

	// idle core right after reset
	assert property (@(posedge clock) $fell(reset) |-> !commit_valid && issue_ready)
		else stop_with_failure("core not idle after reset");

	assert property (@(posedge clock) disable iff (reset) commit_valid |-> !exp_empty)
		else stop_with_failure("commit with no instruction outstanding");

	assert property (@(posedge clock) disable iff (reset)
		commit_valid && !exp_empty |-> commit_rd == exp_head_rd)
		else stop_with_failure($sformatf("Mismatch at %0t: commit_rd = %0d, expected %0d",
			$time, $sampled(commit_rd), $sampled(exp_head_rd)));

	assert property (@(posedge clock) disable iff (reset)
		commit_valid && !exp_empty |-> commit_data == exp_head_data)
		else stop_with_failure($sformatf("Mismatch at %0t: commit_data = %h, expected %h",
			$time, $sampled(commit_data), $sampled(exp_head_data)));

	////////////////////////////////////////////////////
	// stimulus

	// called at a falling edge, returns at the edge after acceptance
	task automatic send_instr(input logic [3:0] op, input reg_idx_t rd, input reg_idx_t rs1,
		input reg_idx_t rs2, input logic use_imm, input word_t imm);
		issue_valid   = 1'b1;
		issue_op      = op;
		issue_rd      = rd;
		issue_rs1     = rs1;
		issue_rs2     = rs2;
		issue_use_imm = use_imm;
		issue_imm     = imm;
		@(negedge clock);
		while (!accepted_last) begin
			@(negedge clock);
		end
		issue_valid = 1'b0;
	endtask

	task automatic idle_cycle();
		issue_valid = 1'b0;
		@(negedge clock);
	endtask

	// alu op over registers lo..hi, a third use the immediate
	task automatic send_random_alu(input int lo, input int hi);
		send_instr(4'($urandom_range(0, 5)), reg_idx_t'($urandom_range(lo, hi)),
			reg_idx_t'($urandom_range(lo, hi)), reg_idx_t'($urandom_range(lo, hi)),
			$urandom_range(0, 2) == 0, $urandom);
	endtask

	initial begin
		void'($urandom(20893));
		issue_valid   = 1'b0;
		issue_op      = '0;
		issue_rd      = '0;
		issue_rs1     = '0;
		issue_rs2     = '0;
		issue_use_imm = 1'b0;
		issue_imm     = '0;
		accepted      = 0;
		committed     = 0;
		stall_cycles  = 0;
		cycle_count   = 0;
		exp_empty     = 1'b1;
		exp_head_rd   = '0;
		exp_head_data = '0;
		@(negedge clock);
		while (reset) begin
			@(negedge clock);
		end

		// random alu and immediate stream with gaps
		for (int i = 0; i < N_RANDOM; i++) begin
			send_random_alu(0, 31);
			if ($urandom_range(0, 3) == 0) begin
				idle_cycle();
			end
		end

		// raw chains, busy overwrite, tight register pool
		send_instr(4'd0, 5'd1, 5'd0, 5'd0, 1'b1, $urandom);
		send_instr(4'd0, 5'd2, 5'd1, 5'd1, 1'b0, '0);
		send_instr(4'd1, 5'd1, 5'd2, 5'd1, 1'b0, '0);
		for (int i = 0; i < N_CHAIN - 3; i++) begin
			send_random_alu(1, 3);
		end

		// multiply then independent alu work
		for (int i = 0; i < 4; i++) begin
			send_instr(4'd0, reg_idx_t'(4 + i), 5'd0, 5'd0, 1'b1, $urandom);
		end
		for (int g = 0; g < 4; g++) begin
			send_instr(4'(8 + g % 2), reg_idx_t'(10 + g), reg_idx_t'(4 + g),
				reg_idx_t'(4 + (g + 1) % 4), 1'b0, '0);
			for (int k = 0; k < 3; k++) begin
				send_instr(4'($urandom_range(0, 5)), reg_idx_t'(20 + k),
					reg_idx_t'(4 + k), reg_idx_t'(5 + k), 1'b0, '0);
			end
		end

		// flood of dependent multiplies
		for (int i = 0; i < N_FLOOD; i++) begin
			if ($urandom_range(0, 2) != 0) begin
				send_instr(4'(8 + $urandom_range(0, 1)), reg_idx_t'($urandom_range(1, 2)),
					reg_idx_t'($urandom_range(1, 2)), reg_idx_t'($urandom_range(1, 2)),
					1'b0, '0);
			end else begin
				send_random_alu(1, 2);
			end
		end

		// r0 writes commit a value, reads stay zero
		send_instr(4'd0, 5'd0, 5'd0, 5'd0, 1'b1, 32'h1234_5678);
		send_instr(4'd0, 5'd0, 5'd4, 5'd5, 1'b0, '0);
		send_instr(4'd0, 5'd7, 5'd0, 5'd0, 1'b0, '0);
		send_instr(4'd5, 5'd8, 5'd0, 5'd4, 1'b0, '0);
		send_instr(4'd8, 5'd9, 5'd0, 5'd5, 1'b0, '0);
		send_instr(4'd4, 5'd10, 5'd0, 5'd0, 1'b1, 32'hffff_ffff);

		// drain, then a few quiet cycles to catch extra commits
		while (committed != accepted) begin
			@(negedge clock);
		end
		repeat (5) @(negedge clock);

		if (exp_rd_q.size() == 0 && accepted == committed && accepted == NUM_INSTR
			&& stall_cycles > 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			stop_with_failure($sformatf(
				"accepted %0d, committed %0d, %0d still expected, %0d stall cycles",
				accepted, committed, exp_rd_q.size(), stall_cycles));
		end
	end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
	output logic clock,
	output logic reset
);

	// 10 ns period
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// high over two rising edges, dropped on a falling edge
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

// ==== ooo_core.f ====
+incdir+design
design/core_pkg.sv
design/dispatch_if.sv
design/rename_stage.sv
design/reorder_buffer.sv
design/reservation_station.sv
design/alu_unit.sv
design/mul_unit.sv
design/cdb_arbiter.sv
design/ooo_core.sv
dv/tb_clock.sv
dv/ooo_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb -f ooo_core.f \
	&& ./obj_dir/Vooo_core_tb | grep -F "RESULT: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
